// ==== soc_cfg.svh ====
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus width, data and address alike
`define SOC_DATA_W       32

// One RAM bank, 64K bytes
`define SOC_TCM_AW       16

`define SOC_GPIO_W       16           // P0 out, P1 in

// Region bases of the address map
`define SOC_TCM0_BASE    32'h0000_0000
`define SOC_TCM1_BASE    32'h0001_0000
`define SOC_PERIPH_BASE  32'h4000_0000

`define SOC_PERIPH_AW    12           // 4K peripheral window

`endif

// ==== ahb_pkg.sv ====
package ahb_pkg;

   // AHB-lite transfer type
   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_BUSY   = 2'b01,
      HTRANS_NONSEQ = 2'b10,
      HTRANS_SEQ    = 2'b11
   } htrans_e;

   typedef enum logic [2:0] {
      HSIZE_BYTE = 3'b000,
      HSIZE_HALF = 3'b001,
      HSIZE_WORD = 3'b010             // Largest size on a 32-bit bus
   } hsize_e;

   typedef enum logic {
      HRESP_OKAY  = 1'b0,
      HRESP_ERROR = 1'b1
   } hresp_e;

   // AHB to APB bridge sequencing
   typedef enum logic [1:0] {
      APB_IDLE,                       // Also the AHB response cycle
      APB_SETUP,
      APB_ACCESS
   } apb_state_e;

endpackage

// ==== soc_map_pkg.sv ====
`include "soc_cfg.svh"

package soc_map_pkg;

   // Target of one transfer
   typedef enum logic [1:0] {
      SEL_TCM0,
      SEL_TCM1,
      SEL_PERIPH,
      SEL_NONE                        // Unmapped, error response
   } slave_sel_e;

   // GPIO registers, byte offsets in the peripheral window
   typedef enum logic [`SOC_PERIPH_AW-1:0] {
      GPIO_DOUT = 'h0,                // Output register, drives P0
      GPIO_DIN  = 'h4                 // Synchronized P1, read only
   } gpio_reg_e;

endpackage

// ==== ahb_slv_if.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

interface ahb_slv_if;

   logic                    hsel;        // Decode of this slave
   logic [`SOC_DATA_W-1:0]  haddr;
   ahb_pkg::htrans_e        htrans;
   logic                    hwrite;
   ahb_pkg::hsize_e         hsize;
   logic [`SOC_DATA_W-1:0]  hwdata;      // Data phase
   logic                    hready;      // Bus ready, from the decoder
   logic [`SOC_DATA_W-1:0]  hrdata;
   logic                    hreadyout;   // Slave ready
   ahb_pkg::hresp_e         hresp;

   modport decoder (
      output hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
      input  hrdata, hreadyout, hresp
   );

   modport slave (
      input  hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
      output hrdata, hreadyout, hresp
   );

endinterface

// ==== apb_if.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

interface apb_if;

   logic                      psel;
   logic                      penable;     // Low in setup, high in access
   logic                      pwrite;
   logic [`SOC_PERIPH_AW-1:0] paddr;       // Offset in the window
   logic [`SOC_DATA_W-1:0]    pwdata;
   logic [`SOC_DATA_W-1:0]    prdata;
   logic                      pready;
   logic                      pslverr;

   modport master (
      output psel, penable, pwrite, paddr, pwdata,
      input  prdata, pready, pslverr
   );

   modport slave (
      input  psel, penable, pwrite, paddr, pwdata,
      output prdata, pready, pslverr
   );

endinterface

// ==== ahb_tcm_ram.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module ahb_tcm_ram (
   input  logic      clk,
   input  logic      rst_i,
   ahb_slv_if.slave  bus_if
);

   localparam int WORD_AW = `SOC_TCM_AW - 2;     // Word index width
   localparam int DEPTH   = 1 << WORD_AW;        // 16K words

   logic [`SOC_DATA_W-1:0] mem [DEPTH];
   logic [`SOC_DATA_W-1:0] rdata_q;              // Read word, one per access
   logic                   ap_accept;
   logic [WORD_AW-1:0]     ap_word;
   logic                   dp_valid_q;           // Data phase pending
   logic                   dp_write_q;
   logic [WORD_AW-1:0]     dp_word_q;
   logic [1:0]             dp_ofs_q;             // Byte offset in word
   ahb_pkg::hsize_e        dp_size_q;
   logic [3:0]             dp_be;                // Byte lanes of the write
   logic                   wr_en;
   logic                   fwd;                  // Read hits the landing write

   assign ap_accept = bus_if.hsel && bus_if.hready &&
                      (bus_if.htrans inside {ahb_pkg::HTRANS_NONSEQ, ahb_pkg::HTRANS_SEQ});
   assign ap_word   = bus_if.haddr[`SOC_TCM_AW-1:2];
   assign wr_en     = dp_valid_q && dp_write_q;  // One cycle data phase
   assign fwd       = wr_en && (ap_word == dp_word_q);

   always_comb begin
      case (dp_size_q)
         ahb_pkg::HSIZE_BYTE: dp_be = 4'b0001 << dp_ofs_q;
         ahb_pkg::HSIZE_HALF: dp_be = dp_ofs_q[1] ? 4'b1100 : 4'b0011;
         default:             dp_be = 4'b1111;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         dp_valid_q <= 1'b0;
      end else begin
         dp_valid_q <= ap_accept;
      end
   end

   always_ff @(posedge clk) begin
      if (ap_accept) begin                       // Address phase sample
         dp_write_q <= bus_if.hwrite;
         dp_word_q  <= ap_word;
         dp_ofs_q   <= bus_if.haddr[1:0];
         dp_size_q  <= bus_if.hsize;
      end
   end

   // Write lands and next read is fetched on the same edge
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (wr_en && dp_be[i]) begin
            mem[dp_word_q][8*i +: 8] <= bus_if.hwdata[8*i +: 8];
         end
         if (ap_accept) begin
            rdata_q[8*i +: 8] <= (fwd && dp_be[i]) ? bus_if.hwdata[8*i +: 8]
                                                   : mem[ap_word][8*i +: 8];
         end
      end
   end

   assign bus_if.hrdata    = rdata_q;
   assign bus_if.hreadyout = 1'b1;               // Zero wait
   assign bus_if.hresp     = ahb_pkg::HRESP_OKAY;

   a_size_max: assert property (@(posedge clk) disable iff (rst_i)
      ap_accept |-> bus_if.hsize <= ahb_pkg::HSIZE_WORD);

   a_aligned: assert property (@(posedge clk) disable iff (rst_i)
      ap_accept |-> !((bus_if.hsize == ahb_pkg::HSIZE_HALF && bus_if.haddr[0]) ||
                      (bus_if.hsize == ahb_pkg::HSIZE_WORD && |bus_if.haddr[1:0])));

endmodule

// ==== ahb_apb_bridge.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module ahb_apb_bridge (
   input  logic      clk,
   input  logic      rst_i,
   ahb_slv_if.slave  ahb_if,
   apb_if.master     apb_m
);

   ahb_pkg::apb_state_e       state_q;
   logic                      ap_accept;
   logic                      apb_done;    // Access phase completes
   logic                      pwrite_q;
   logic [`SOC_PERIPH_AW-1:0] paddr_q;
   logic [`SOC_DATA_W-1:0]    pwdata_q;
   logic [`SOC_DATA_W-1:0]    prdata_q;
   logic                      err_q;       // Second cycle of ERROR

   assign ap_accept = ahb_if.hsel && ahb_if.hready &&
                      (ahb_if.htrans inside {ahb_pkg::HTRANS_NONSEQ, ahb_pkg::HTRANS_SEQ});
   assign apb_done  = (state_q == ahb_pkg::APB_ACCESS) && apb_m.pready;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= ahb_pkg::APB_IDLE;
         err_q   <= 1'b0;
      end else begin
         err_q <= apb_done && apb_m.pslverr;
         case (state_q)
            ahb_pkg::APB_IDLE: begin
               if (ap_accept) begin
                  state_q <= ahb_pkg::APB_SETUP;
               end
            end
            ahb_pkg::APB_SETUP:  state_q <= ahb_pkg::APB_ACCESS;
            ahb_pkg::APB_ACCESS: begin
               if (apb_m.pready) begin
                  state_q <= ahb_pkg::APB_IDLE;   // Response cycle follows
               end
            end
            default: state_q <= ahb_pkg::APB_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ap_accept) begin
         paddr_q  <= ahb_if.haddr[`SOC_PERIPH_AW-1:0];
         pwrite_q <= ahb_if.hwrite;
      end
      if (state_q == ahb_pkg::APB_SETUP) begin
         pwdata_q <= ahb_if.hwdata;               // First data phase cycle
      end
      if (apb_done && !pwrite_q) begin
         prdata_q <= apb_m.prdata;
      end
   end

   assign apb_m.psel    = (state_q != ahb_pkg::APB_IDLE);
   assign apb_m.penable = (state_q == ahb_pkg::APB_ACCESS);
   assign apb_m.pwrite  = pwrite_q;
   assign apb_m.paddr   = paddr_q;
   // Setup phase sees hwdata before it is held
   assign apb_m.pwdata  = (state_q == ahb_pkg::APB_SETUP) ? ahb_if.hwdata : pwdata_q;

   assign ahb_if.hrdata    = prdata_q;
   assign ahb_if.hreadyout = (state_q == ahb_pkg::APB_IDLE);
   // Low ready ERROR in access then high ready ERROR after it
   assign ahb_if.hresp     = ((apb_done && apb_m.pslverr) || err_q) ? ahb_pkg::HRESP_ERROR
                                                                     : ahb_pkg::HRESP_OKAY;

   // Access keeps psel and the setup address, direction and data
   a_apb_enable: assert property (@(posedge clk) disable iff (rst_i)
      apb_m.penable |-> apb_m.psel && $stable(apb_m.paddr) && $stable(apb_m.pwrite) &&
                        $stable(apb_m.pwdata));

endmodule

// ==== gpio_apb.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module gpio_apb (
   input  logic                   clk,
   input  logic                   rst_i,
   apb_if.slave                   apb_s,
   input  logic [`SOC_GPIO_W-1:0] gpio_in_i,
   output logic [`SOC_GPIO_W-1:0] gpio_out_o
);

   logic [`SOC_GPIO_W-1:0] dout_q;
   logic [`SOC_GPIO_W-1:0] din_meta_q;    // First sync stage
   logic [`SOC_GPIO_W-1:0] din_q;         // Stable input
   logic                   wr_dout;

   assign wr_dout = apb_s.psel && apb_s.penable && apb_s.pwrite &&
                    (apb_s.paddr == soc_map_pkg::GPIO_DOUT);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         dout_q <= '0;
      end else if (wr_dout) begin
         dout_q <= apb_s.pwdata[`SOC_GPIO_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      din_meta_q <= gpio_in_i;
      din_q      <= din_meta_q;
   end

   // Unknown offsets read as zero
   always_comb begin
      case (apb_s.paddr)
         soc_map_pkg::GPIO_DOUT: apb_s.prdata = {{(`SOC_DATA_W-`SOC_GPIO_W){1'b0}}, dout_q};
         soc_map_pkg::GPIO_DIN:  apb_s.prdata = {{(`SOC_DATA_W-`SOC_GPIO_W){1'b0}}, din_q};
         default:                apb_s.prdata = '0;
      endcase
   end

   assign apb_s.pready  = 1'b1;           // No wait states
   assign apb_s.pslverr = 1'b0;
   assign gpio_out_o    = dout_q;

endmodule

// ==== ahb_decoder.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module ahb_decoder (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic [`SOC_DATA_W-1:0] haddr_i,
   input  logic [1:0]             htrans_i,
   input  logic                   hwrite_i,
   input  logic [2:0]             hsize_i,
   input  logic [`SOC_DATA_W-1:0] hwdata_i,
   output logic [`SOC_DATA_W-1:0] hrdata_o,
   output logic                   hready_o,
   output logic                   hresp_o,
   ahb_slv_if.decoder             tcm0_if,
   ahb_slv_if.decoder             tcm1_if,
   ahb_slv_if.decoder             periph_if
);

   localparam logic [`SOC_DATA_W-1:0] TCM0_BASE   = `SOC_TCM0_BASE;
   localparam logic [`SOC_DATA_W-1:0] TCM1_BASE   = `SOC_TCM1_BASE;
   localparam logic [`SOC_DATA_W-1:0] PERIPH_BASE = `SOC_PERIPH_BASE;

   ahb_pkg::htrans_e        ap_trans;
   ahb_pkg::hsize_e         ap_size;
   logic                    ap_valid;      // NONSEQ or SEQ
   soc_map_pkg::slave_sel_e ap_sel;
   soc_map_pkg::slave_sel_e dp_sel_q;      // Owner of the data phase
   logic                    dp_active_q;
   logic                    err_second_q;  // Unmapped, ready cycle

   assign ap_trans = ahb_pkg::htrans_e'(htrans_i);
   assign ap_size  = ahb_pkg::hsize_e'(hsize_i);
   assign ap_valid = ap_trans inside {ahb_pkg::HTRANS_NONSEQ, ahb_pkg::HTRANS_SEQ};

   always_comb begin
      if (haddr_i[`SOC_DATA_W-1:`SOC_TCM_AW] == TCM0_BASE[`SOC_DATA_W-1:`SOC_TCM_AW]) begin
         ap_sel = soc_map_pkg::SEL_TCM0;
      end else if (haddr_i[`SOC_DATA_W-1:`SOC_TCM_AW] ==
                   TCM1_BASE[`SOC_DATA_W-1:`SOC_TCM_AW]) begin
         ap_sel = soc_map_pkg::SEL_TCM1;
      end else if (haddr_i[`SOC_DATA_W-1:`SOC_PERIPH_AW] ==
                   PERIPH_BASE[`SOC_DATA_W-1:`SOC_PERIPH_AW]) begin
         ap_sel = soc_map_pkg::SEL_PERIPH;
      end else begin
         ap_sel = soc_map_pkg::SEL_NONE;
      end
   end

   // Address phase goes to every slave, hsel picks one
   assign tcm0_if.hsel     = (ap_sel == soc_map_pkg::SEL_TCM0);
   assign tcm0_if.haddr    = haddr_i;
   assign tcm0_if.htrans   = ap_trans;
   assign tcm0_if.hwrite   = hwrite_i;
   assign tcm0_if.hsize    = ap_size;
   assign tcm0_if.hwdata   = hwdata_i;
   assign tcm0_if.hready   = hready_o;

   assign tcm1_if.hsel     = (ap_sel == soc_map_pkg::SEL_TCM1);
   assign tcm1_if.haddr    = haddr_i;
   assign tcm1_if.htrans   = ap_trans;
   assign tcm1_if.hwrite   = hwrite_i;
   assign tcm1_if.hsize    = ap_size;
   assign tcm1_if.hwdata   = hwdata_i;
   assign tcm1_if.hready   = hready_o;

   assign periph_if.hsel   = (ap_sel == soc_map_pkg::SEL_PERIPH);
   assign periph_if.haddr  = haddr_i;
   assign periph_if.htrans = ap_trans;
   assign periph_if.hwrite = hwrite_i;
   assign periph_if.hsize  = ap_size;
   assign periph_if.hwdata = hwdata_i;
   assign periph_if.hready = hready_o;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         dp_active_q  <= 1'b0;
         dp_sel_q     <= soc_map_pkg::SEL_NONE;
         err_second_q <= 1'b0;
      end else begin
         err_second_q <= dp_active_q && (dp_sel_q == soc_map_pkg::SEL_NONE) && !err_second_q;
         if (hready_o) begin                 // Data phase advances
            dp_active_q <= ap_valid;
            dp_sel_q    <= ap_sel;
         end
      end
   end

   // Response of the slave that owns the data phase
   always_comb begin
      hrdata_o = '0;
      hready_o = 1'b1;
      hresp_o  = ahb_pkg::HRESP_OKAY;
      if (dp_active_q) begin
         case (dp_sel_q)
            soc_map_pkg::SEL_TCM0: begin
               hrdata_o = tcm0_if.hrdata;
               hready_o = tcm0_if.hreadyout;
               hresp_o  = tcm0_if.hresp;
            end
            soc_map_pkg::SEL_TCM1: begin
               hrdata_o = tcm1_if.hrdata;
               hready_o = tcm1_if.hreadyout;
               hresp_o  = tcm1_if.hresp;
            end
            soc_map_pkg::SEL_PERIPH: begin
               hrdata_o = periph_if.hrdata;
               hready_o = periph_if.hreadyout;
               hresp_o  = periph_if.hresp;
            end
            default: begin                   // Two cycle ERROR
               hready_o = err_second_q;
               hresp_o  = ahb_pkg::HRESP_ERROR;
            end
         endcase
      end
   end

   // Holds for the local error and for any slave error
   a_err_two_cycle: assert property (@(posedge clk) disable iff (rst_i)
      (hresp_o == ahb_pkg::HRESP_ERROR && !hready_o) |=>
      (hresp_o == ahb_pkg::HRESP_ERROR && hready_o));

endmodule

// ==== soc_fabric_top.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_fabric_top (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic [`SOC_DATA_W-1:0] haddr_i,
   input  logic [1:0]             htrans_i,
   input  logic                   hwrite_i,
   input  logic [2:0]             hsize_i,
   input  logic [`SOC_DATA_W-1:0] hwdata_i,
   output logic [`SOC_DATA_W-1:0] hrdata_o,
   output logic                   hready_o,
   output logic                   hresp_o,
   input  logic [`SOC_GPIO_W-1:0] gpio_in_i,    // P1
   output logic [`SOC_GPIO_W-1:0] gpio_out_o    // P0
);

   ahb_slv_if tcm0_if ();
   ahb_slv_if tcm1_if ();
   ahb_slv_if periph_if ();
   apb_if     gpio_apb_if ();                   // Bridge to GPIO

   ahb_decoder u_decoder (
      .clk       (clk),
      .rst_i     (rst_i),
      .haddr_i   (haddr_i),
      .htrans_i  (htrans_i),
      .hwrite_i  (hwrite_i),
      .hsize_i   (hsize_i),
      .hwdata_i  (hwdata_i),
      .hrdata_o  (hrdata_o),
      .hready_o  (hready_o),
      .hresp_o   (hresp_o),
      .tcm0_if   (tcm0_if.decoder),
      .tcm1_if   (tcm1_if.decoder),
      .periph_if (periph_if.decoder)
   );

   ahb_tcm_ram u_tcm0 (
      .clk    (clk),
      .rst_i  (rst_i),
      .bus_if (tcm0_if.slave)
   );

   ahb_tcm_ram u_tcm1 (
      .clk    (clk),
      .rst_i  (rst_i),
      .bus_if (tcm1_if.slave)
   );

   ahb_apb_bridge u_bridge (
      .clk    (clk),
      .rst_i  (rst_i),
      .ahb_if (periph_if.slave),
      .apb_m  (gpio_apb_if.master)
   );

   gpio_apb u_gpio (
      .clk        (clk),
      .rst_i      (rst_i),
      .apb_s      (gpio_apb_if.slave),
      .gpio_in_i  (gpio_in_i),
      .gpio_out_o (gpio_out_o)
   );

endmodule

// ==== tb_soc_fabric.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc_fabric;

   localparam int MAX_CYCLES = 2000;              // About 300 transfers of 3 cycles plus margin

   logic                   clk;
   logic                   rst_i;
   logic [`SOC_DATA_W-1:0] haddr_i;
   logic [1:0]             htrans_i;
   logic                   hwrite_i;
   logic [2:0]             hsize_i;
   logic [`SOC_DATA_W-1:0] hwdata_i;
   logic [`SOC_DATA_W-1:0] hrdata_o;
   logic                   hready_o;
   logic                   hresp_o;
   logic [`SOC_GPIO_W-1:0] gpio_in_i;
   logic [`SOC_GPIO_W-1:0] gpio_out_o;

   integer seed = 87;
   int     cycles = 0;
   int     checks = 0;
   int     errors = 0;
   logic [31:0] ram_model [logic [31:0]];         // Expected RAM words by word address

   soc_fabric_top i_dut (
      .clk        (clk),
      .rst_i      (rst_i),
      .haddr_i    (haddr_i),
      .htrans_i   (htrans_i),
      .hwrite_i   (hwrite_i),
      .hsize_i    (hsize_i),
      .hwdata_i   (hwdata_i),
      .hrdata_o   (hrdata_o),
      .hready_o   (hready_o),
      .hresp_o    (hresp_o),
      .gpio_in_i  (gpio_in_i),
      .gpio_out_o (gpio_out_o)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Run timed out after %0d cycles, a transfer never completed", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0d ns: %s: got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   // Address phase held until the bus is ready
   task automatic addr_phase(input logic [31:0] addr, input logic write, input logic [2:0] size);
      haddr_i  = addr;
      htrans_i = ahb_pkg::HTRANS_NONSEQ;
      hwrite_i = write;
      hsize_i  = size;
      @(negedge clk);
      while (!hready_o) begin
         @(negedge clk);
      end
      @(posedge clk);                              // Accepted here
      #2;
      htrans_i = ahb_pkg::HTRANS_IDLE;
   endtask

   // Waits out the data phase and samples mid cycle
   task automatic data_phase(output logic [31:0] rdata, output logic resp,
                             output int waits, output logic low_resp);
      waits    = 0;
      low_resp = ahb_pkg::HRESP_OKAY;
      @(negedge clk);
      while (!hready_o) begin
         waits++;
         low_resp = hresp_o;                       // Response while stalled
         @(negedge clk);
      end
      rdata = hrdata_o;
      resp  = hresp_o;
      @(posedge clk);
      #2;
   endtask

   task automatic ahb_write(input logic [31:0] addr, input logic [2:0] size,
                            input logic [31:0] data, output logic resp, output int waits);
      logic [31:0] unused_rdata;
      logic        low_resp;
      addr_phase(addr, 1'b1, size);
      hwdata_i = data;                             // Valid for the whole data phase
      data_phase(unused_rdata, resp, waits, low_resp);
   endtask

   task automatic ahb_read(input logic [31:0] addr, input logic [2:0] size,
                           output logic [31:0] rdata, output logic resp,
                           output int waits, output logic low_resp);
      addr_phase(addr, 1'b0, size);
      data_phase(rdata, resp, waits, low_resp);
   endtask

   // New word after a write with data on its own lanes
   function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] addr,
                                                input logic [2:0] size,
                                                input logic [31:0] data);
      logic [31:0] mask;
      case (size)
         ahb_pkg::HSIZE_BYTE: mask = 32'h0000_00FF << (8 * addr[1:0]);
         ahb_pkg::HSIZE_HALF: mask = 32'h0000_FFFF << (16 * addr[1]);
         default:             mask = 32'hFFFF_FFFF;
      endcase
      return (old_word & ~mask) | (data & mask);
   endfunction

   task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
                              input logic [31:0] data);
      logic [31:0] waddr;
      logic [31:0] old_word;
      waddr    = addr & 32'hFFFF_FFFC;
      old_word = ram_model.exists(waddr) ? ram_model[waddr] : 32'h0;
      ram_model[waddr] = merge_lanes(old_word, addr, size, data);
   endtask

   task automatic ram_write(input logic [31:0] addr, input logic [2:0] size,
                            input logic [31:0] data);
      logic resp;
      int   waits;
      ahb_write(addr, size, data, resp, waits);
      check_eq(resp, ahb_pkg::HRESP_OKAY, $sformatf("write resp at %h", addr));
      check_eq(waits, 0, $sformatf("write wait states at %h", addr));
      model_write(addr, size, data);
   endtask

   task automatic ram_read_check(input logic [31:0] addr, input string tag);
      logic [31:0] rdata;
      logic        resp;
      logic        low_resp;
      int          waits;
      ahb_read(addr, ahb_pkg::HSIZE_WORD, rdata, resp, waits, low_resp);
      check_eq(resp, ahb_pkg::HRESP_OKAY, $sformatf("%s resp at %h", tag, addr));
      check_eq(waits, 0, $sformatf("%s wait states at %h", tag, addr));
      check_eq(rdata, ram_model[addr & 32'hFFFF_FFFC], $sformatf("%s data at %h", tag, addr));
   endtask

   // Read of the same word issued in the data phase of the write
   task automatic write_then_read(input logic [31:0] addr, input logic [2:0] size,
                                  input logic [31:0] data);
      logic [31:0] rdata;
      logic        resp;
      logic        low_resp;
      int          waits;
      addr_phase(addr, 1'b1, size);
      hwdata_i = data;
      model_write(addr, size, data);
      addr_phase(addr & 32'hFFFF_FFFC, 1'b0, ahb_pkg::HSIZE_WORD);
      data_phase(rdata, resp, waits, low_resp);
      check_eq(resp, ahb_pkg::HRESP_OKAY, "back to back resp");
      check_eq(waits, 0, "back to back wait states");
      check_eq(rdata, ram_model[addr & 32'hFFFF_FFFC], $sformatf("back to back at %h", addr));
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         $display("Test %s: ok", name);
      end else begin
         $display("Test %s: %0d mismatches", name, errors - errors_before);
      end
   endtask

   task automatic reset_state();
      int e0;
      e0 = errors;
      @(negedge clk);
      check_eq(hready_o, 1'b1, "hready after reset");
      check_eq(hresp_o, ahb_pkg::HRESP_OKAY, "hresp after reset");
      check_eq(gpio_out_o, '0, "gpio_out after reset");
      @(posedge clk);
      #2;
      report_test("reset", e0);
   endtask

   task automatic tcm0_words();
      logic [31:0] addrs [$];
      logic [31:0] addr;
      int          e0;
      e0 = errors;
      for (int i = 0; i < 16; i++) begin
         addr = `SOC_TCM0_BASE + ($random(seed) & 32'h0000_FFFC);   // Aligned offset
         ram_write(addr, ahb_pkg::HSIZE_WORD, $random(seed));
         addrs.push_back(addr);
      end
      foreach (addrs[i]) begin
         ram_read_check(addrs[i], "tcm0 word");
      end
      report_test("tcm0 words", e0);
   endtask

   task automatic tcm1_byte_lanes();
      logic [31:0] base;
      int          e0;
      e0   = errors;
      base = `SOC_TCM1_BASE + 32'h0000_0100;
      ram_write(base, ahb_pkg::HSIZE_WORD, 32'h1122_3344);
      ram_write(base + 1, ahb_pkg::HSIZE_BYTE, 32'h7766_AB55);       // Only lane 1 lands
      ram_write(base + 2, ahb_pkg::HSIZE_HALF, 32'hCDEF_1234);       // Upper half lands
      ram_read_check(base, "tcm1 merge");
      ram_write(base + 4, ahb_pkg::HSIZE_WORD, 32'h0BAD_F00D);
      write_then_read(base + 4, ahb_pkg::HSIZE_WORD, $random(seed));
      write_then_read(base + 3, ahb_pkg::HSIZE_BYTE, 32'h5C6D_7E8F);  // Partial forward
      write_then_read(base + 4, ahb_pkg::HSIZE_HALF, 32'h1357_7E81);
      report_test("tcm1 lanes", e0);
   endtask

   task automatic bank_separation();
      int e0;
      e0 = errors;
      ram_write(`SOC_TCM0_BASE + 32'h40, ahb_pkg::HSIZE_WORD, 32'hA5A5_0001);
      ram_write(`SOC_TCM1_BASE + 32'h40, ahb_pkg::HSIZE_WORD, 32'h5A5A_0002);
      ram_read_check(`SOC_TCM0_BASE + 32'h40, "bank tcm0");
      ram_read_check(`SOC_TCM1_BASE + 32'h40, "bank tcm1");
      report_test("bank separation", e0);
   endtask

   task automatic gpio_access();
      logic [31:0]            rdata;
      logic                   resp;
      logic                   low_resp;
      int                     waits;
      logic [`SOC_GPIO_W-1:0] pattern;
      int                     e0;
      e0      = errors;
      pattern = $random(seed);
      ahb_write(`SOC_PERIPH_BASE + soc_map_pkg::GPIO_DOUT, ahb_pkg::HSIZE_WORD,
                {16'h0, pattern}, resp, waits);
      check_eq(resp, ahb_pkg::HRESP_OKAY, "DOUT write resp");
      check_eq(waits, 2, "DOUT write wait states");
      check_eq(gpio_out_o, pattern, "gpio_out after DOUT write");
      ahb_read(`SOC_PERIPH_BASE + soc_map_pkg::GPIO_DOUT, ahb_pkg::HSIZE_WORD,
               rdata, resp, waits, low_resp);
      check_eq(resp, ahb_pkg::HRESP_OKAY, "DOUT read resp");
      check_eq(waits, 2, "DOUT read wait states");
      check_eq(rdata, {16'h0, pattern}, "DOUT read back");
      gpio_in_i = ~pattern;
      repeat (4) @(posedge clk);                   // Through the synchronizer
      #2;
      ahb_read(`SOC_PERIPH_BASE + soc_map_pkg::GPIO_DIN, ahb_pkg::HSIZE_WORD,
               rdata, resp, waits, low_resp);
      check_eq(resp, ahb_pkg::HRESP_OKAY, "DIN read resp");
      check_eq(waits, 2, "DIN read wait states");
      check_eq(rdata, {16'h0, ~pattern}, "DIN read");
      report_test("gpio", e0);
   endtask

   task automatic unmapped_error();
      logic [31:0] rdata;
      logic        resp;
      logic        low_resp;
      int          waits;
      int          e0;
      e0 = errors;
      ahb_read(32'h2000_0000, ahb_pkg::HSIZE_WORD, rdata, resp, waits, low_resp);
      check_eq(waits, 1, "unmapped stall cycles");
      check_eq(low_resp, ahb_pkg::HRESP_ERROR, "unmapped first cycle resp");
      check_eq(resp, ahb_pkg::HRESP_ERROR, "unmapped second cycle resp");
      ram_read_check(`SOC_TCM0_BASE + 32'h40, "after error");   // Bus recovers
      report_test("unmapped", e0);
   endtask

   initial begin
      clk       = 1'b0;
      rst_i     = 1'b1;
      haddr_i   = '0;
      htrans_i  = ahb_pkg::HTRANS_IDLE;
      hwrite_i  = 1'b0;
      hsize_i   = ahb_pkg::HSIZE_WORD;
      hwdata_i  = '0;
      gpio_in_i = '0;
      repeat (5) @(posedge clk);
      #2;
      rst_i = 1'b0;
      reset_state();
      tcm0_words();
      tcm1_byte_lanes();
      bank_separation();
      gpio_access();
      unmapped_error();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+.
ahb_pkg.sv
soc_map_pkg.sv
ahb_slv_if.sv
apb_if.sv
ahb_tcm_ram.sv
ahb_apb_bridge.sv
gpio_apb.sv
ahb_decoder.sv
soc_fabric_top.sv
tb_soc_fabric.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - include_dirs:
      - .
    files:
      - ahb_pkg.sv
      - soc_map_pkg.sv
      - ahb_slv_if.sv
      - apb_if.sv
      - ahb_tcm_ram.sv
      - ahb_apb_bridge.sv
      - gpio_apb.sv
      - ahb_decoder.sv
      - soc_fabric_top.sv
      - target: test
        files:
          - tb_soc_fabric.sv
